// File: axi_lite_mux.sv
// AXI4-Lite mux top: four upstream manager ports merged onto one downstream port
module axi_lite_mux
  import axi_lite_mux_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  // Upstream write
  input  addr_t [NUM_PORTS-1:0] slv_aw_addr_i,
  input  prot_t [NUM_PORTS-1:0] slv_aw_prot_i,
  input  logic  [NUM_PORTS-1:0] slv_aw_valid_i,
  output logic  [NUM_PORTS-1:0] slv_aw_ready_o,
  input  data_t [NUM_PORTS-1:0] slv_w_data_i,
  input  strb_t [NUM_PORTS-1:0] slv_w_strb_i,
  input  logic  [NUM_PORTS-1:0] slv_w_valid_i,
  output logic  [NUM_PORTS-1:0] slv_w_ready_o,
  output resp_t [NUM_PORTS-1:0] slv_b_resp_o,
  output logic  [NUM_PORTS-1:0] slv_b_valid_o,
  input  logic  [NUM_PORTS-1:0] slv_b_ready_i,
  // Upstream read
  input  addr_t [NUM_PORTS-1:0] slv_ar_addr_i,
  input  prot_t [NUM_PORTS-1:0] slv_ar_prot_i,
  input  logic  [NUM_PORTS-1:0] slv_ar_valid_i,
  output logic  [NUM_PORTS-1:0] slv_ar_ready_o,
  output data_t [NUM_PORTS-1:0] slv_r_data_o,
  output resp_t [NUM_PORTS-1:0] slv_r_resp_o,
  output logic  [NUM_PORTS-1:0] slv_r_valid_o,
  input  logic  [NUM_PORTS-1:0] slv_r_ready_i,
  // Downstream write
  output addr_t                 mst_aw_addr_o,
  output prot_t                 mst_aw_prot_o,
  output logic                  mst_aw_valid_o,
  input  logic                  mst_aw_ready_i,
  output data_t                 mst_w_data_o,
  output strb_t                 mst_w_strb_o,
  output logic                  mst_w_valid_o,
  input  logic                  mst_w_ready_i,
  input  resp_t                 mst_b_resp_i,
  input  logic                  mst_b_valid_i,
  output logic                  mst_b_ready_o,
  // Downstream read
  output addr_t                 mst_ar_addr_o,
  output prot_t                 mst_ar_prot_o,
  output logic                  mst_ar_valid_o,
  input  logic                  mst_ar_ready_i,
  input  data_t                 mst_r_data_i,
  input  resp_t                 mst_r_resp_i,
  input  logic                  mst_r_valid_i,
  output logic                  mst_r_ready_o
);

  // Write and read paths are independent, port names match one to one
  write_mux i_write_mux (.*);

  read_mux i_read_mux (.*);

endmodule

// File: axi_lite_mux_pkg.sv
// AXI4-Lite mux package: port count, outstanding limit and channel field types
package axi_lite_mux_pkg;

  // --------------------------------------------------
  // Sizes
  // --------------------------------------------------
  // Upstream manager ports merged onto one downstream port
  localparam int unsigned NUM_PORTS = 4;
  // Routing FIFO depth, also the outstanding limit per direction
  localparam int unsigned MAX_TRANS = 4;

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned STRB_W = DATA_W / 8;

  // --------------------------------------------------
  // Channel fields
  // --------------------------------------------------
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;
  typedef logic [2:0]        prot_t;
  typedef logic [1:0]        resp_t;

  // Upstream port index, as stored in the routing FIFOs
  typedef logic [$clog2(NUM_PORTS)-1:0] sel_t;

  // Width of an address beat as arbitrated and spilled, prot above addr
  localparam int unsigned AX_W = ADDR_W + $bits(prot_t);

  // Response codes
  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

endpackage

// File: read_mux.sv
// Read path of the mux: AR arbitration gated by R route space, R response routing
module read_mux
  import axi_lite_mux_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  // Upstream managers
  input  addr_t [NUM_PORTS-1:0] slv_ar_addr_i,
  input  prot_t [NUM_PORTS-1:0] slv_ar_prot_i,
  input  logic  [NUM_PORTS-1:0] slv_ar_valid_i,
  output logic  [NUM_PORTS-1:0] slv_ar_ready_o,
  output data_t [NUM_PORTS-1:0] slv_r_data_o,
  output resp_t [NUM_PORTS-1:0] slv_r_resp_o,
  output logic  [NUM_PORTS-1:0] slv_r_valid_o,
  input  logic  [NUM_PORTS-1:0] slv_r_ready_i,
  // Downstream subordinate
  output addr_t                 mst_ar_addr_o,
  output prot_t                 mst_ar_prot_o,
  output logic                  mst_ar_valid_o,
  input  logic                  mst_ar_ready_i,
  input  data_t                 mst_r_data_i,
  input  resp_t                 mst_r_resp_i,
  input  logic                  mst_r_valid_i,
  output logic                  mst_r_ready_o
);

  logic [NUM_PORTS-1:0][AX_W-1:0] slv_ar_chans;
  logic [AX_W-1:0] ar_chan, mst_ar_chan;
  sel_t ar_sel, r_sel;
  logic ar_req, ar_gnt;
  logic ar_spill_valid, ar_spill_ready;
  logic r_fifo_push, r_fifo_pop, r_fifo_full, r_fifo_empty;

  // --------------------------------------------------
  // AR channel
  // --------------------------------------------------
  for (genvar i = 0; i < NUM_PORTS; i++) begin : gen_ar_chans
    assign slv_ar_chans[i] = {slv_ar_prot_i[i], slv_ar_addr_i[i]};
  end

  rr_arbiter #(
    .WIDTH ( AX_W )
  ) i_ar_arbiter (
    .clk_i    ( clk_i          ),
    .arst_n_i ( arst_n_i       ),
    .req_i    ( slv_ar_valid_i ),
    .gnt_o    ( slv_ar_ready_o ),
    .data_i   ( slv_ar_chans   ),
    .req_o    ( ar_req         ),
    .gnt_i    ( ar_gnt         ),
    .data_o   ( ar_chan        ),
    .idx_o    ( ar_sel         )
  );

  // Handshake only with R route space, push on the same edge
  // R cannot return before AR leaves, so no valid lock
  assign ar_spill_valid = ~r_fifo_full & ar_req;
  assign ar_gnt         = ~r_fifo_full & ar_spill_ready;
  assign r_fifo_push    = ar_spill_valid & ar_spill_ready;

  spill_register #(
    .WIDTH ( AX_W )
  ) i_ar_spill (
    .clk_i    ( clk_i          ),
    .arst_n_i ( arst_n_i       ),
    .valid_i  ( ar_spill_valid ),
    .ready_o  ( ar_spill_ready ),
    .data_i   ( ar_chan        ),
    .valid_o  ( mst_ar_valid_o ),
    .ready_i  ( mst_ar_ready_i ),
    .data_o   ( mst_ar_chan    )
  );

  assign {mst_ar_prot_o, mst_ar_addr_o} = mst_ar_chan;

  route_fifo #(
    .DEPTH ( MAX_TRANS )
  ) i_r_fifo (
    .clk_i    ( clk_i        ),
    .arst_n_i ( arst_n_i     ),
    .push_i   ( r_fifo_push  ),
    .data_i   ( ar_sel       ),
    .pop_i    ( r_fifo_pop   ),
    .data_o   ( r_sel        ),
    .full_o   ( r_fifo_full  ),
    .empty_o  ( r_fifo_empty )
  );

  // --------------------------------------------------
  // R channel
  // --------------------------------------------------
  // Data and response fan out, valid only to the head port
  for (genvar i = 0; i < NUM_PORTS; i++) begin : gen_r_resp
    assign slv_r_data_o[i]  = mst_r_data_i;
    assign slv_r_resp_o[i]  = mst_r_resp_i;
    assign slv_r_valid_o[i] = mst_r_valid_i & ~r_fifo_empty & (r_sel == sel_t'(i));
  end

  assign mst_r_ready_o = ~r_fifo_empty & slv_r_ready_i[r_sel];
  assign r_fifo_pop    = mst_r_valid_i & mst_r_ready_o;

endmodule

// File: route_fifo.sv
// Routing FIFO: keeps upstream port indices in arrival order for response steering
module route_fifo
  import axi_lite_mux_pkg::*;
#(
  parameter int unsigned DEPTH = 4
) (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic push_i,
  input  sel_t data_i,
  input  logic pop_i,
  output sel_t data_o,
  output logic full_o,
  output logic empty_o
);

  // Circular buffer storage
  sel_t                       mem_q [DEPTH];
  logic [$clog2(DEPTH)-1:0]   wr_ptr_q, rd_ptr_q;
  logic [$clog2(DEPTH+1)-1:0] count_q;
  logic                       do_push, do_pop;

  assign full_o  = (count_q == ($clog2(DEPTH+1))'(DEPTH));
  assign empty_o = (count_q == '0);
  // Head is registered, a push shows one cycle later
  assign data_o  = mem_q[rd_ptr_q];

  // Ignore push when full and pop when empty
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        if (wr_ptr_q == ($clog2(DEPTH))'(DEPTH - 1)) begin
          wr_ptr_q <= '0;
        end else begin
          wr_ptr_q <= wr_ptr_q + 1'b1;
        end
      end
      if (do_pop) begin
        if (rd_ptr_q == ($clog2(DEPTH))'(DEPTH - 1)) begin
          rd_ptr_q <= '0;
        end else begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
      end
      // Occupancy, unchanged on simultaneous push and pop
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// File: rr_arbiter.sv
// Round-robin arbiter with lock-in, picks one upstream request and its payload
module rr_arbiter
  import axi_lite_mux_pkg::*;
#(
  parameter int unsigned WIDTH = AX_W
) (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  input  logic [NUM_PORTS-1:0]              req_i,
  output logic [NUM_PORTS-1:0]              gnt_o,
  input  logic [NUM_PORTS-1:0][WIDTH-1:0]   data_i,
  output logic                              req_o,
  input  logic                              gnt_i,
  output logic [WIDTH-1:0]                  data_o,
  output sel_t                              idx_o
);

  // Search start, one past the last winner
  sel_t ptr_q;
  // Held decision while the downstream stalls
  logic lock_q;
  sel_t lock_idx_q;
  sel_t search_idx, cand, idx;
  logic found;

  // --------------------------------------------------
  // Decision
  // --------------------------------------------------
  // First requester at or after the pointer
  always_comb begin
    found      = 1'b0;
    search_idx = ptr_q;
    cand       = ptr_q;
    for (int i = 0; i < NUM_PORTS; i++) begin
      cand = sel_t'((int'(ptr_q) + i) % NUM_PORTS);
      if (!found && req_i[cand]) begin
        found      = 1'b1;
        search_idx = cand;
      end
    end
  end

  // Locked index wins, payload must not change under a pending request
  assign idx    = lock_q ? lock_idx_q : search_idx;
  assign idx_o  = idx;
  assign req_o  = req_i[idx];
  assign data_o = data_i[idx];

  // Grant back to the winning port only
  always_comb begin
    gnt_o      = '0;
    gnt_o[idx] = req_o & gnt_i;
  end

  // --------------------------------------------------
  // State
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ptr_q      <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      // Lock while valid without handshake
      lock_q     <= req_o & ~gnt_i;
      lock_idx_q <= idx;
      // Move past the winner on its handshake
      if (req_o && gnt_i) begin
        ptr_q <= sel_t'((int'(idx) + 1) % NUM_PORTS);
      end
    end
  end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the AXI4-Lite mux testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module tb_axi_lite_mux -o sim_tb \
  && ./obj_dir/sim_tb | tee sim.log \
  && grep -q "Simulation PASSED" sim.log \
  && echo "run_sim: pass" \
  || { echo "run_sim: fail"; exit 1; }

// File: sources.f
axi_lite_mux_pkg.sv
spill_register.sv
route_fifo.sv
rr_arbiter.sv
write_mux.sv
read_mux.sv
axi_lite_mux.sv
tb_axi_lite_mux.sv

// File: spill_register.sv
// Spill register: two-slot valid/ready slice that cuts every combinational path
module spill_register #(
  parameter int unsigned WIDTH = 8
) (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  logic             valid_i,
  output logic             ready_o,
  input  logic [WIDTH-1:0] data_i,
  output logic             valid_o,
  input  logic             ready_i,
  output logic [WIDTH-1:0] data_o
);

  // Slot A takes new input, slot B holds a stalled beat
  logic             a_full_q, b_full_q;
  logic [WIDTH-1:0] a_data_q, b_data_q;
  logic             a_fill, a_drain, b_fill, b_drain;

  // Input beat lands in A
  assign a_fill  = valid_i & ready_o;
  // A leaves every cycle B is free, either downstream or into B
  assign a_drain = a_full_q & ~b_full_q;
  // Output stalled, park the A beat in B
  assign b_fill  = a_drain & ~ready_i;
  assign b_drain = b_full_q & ready_i;

  // Register state only, no path from ready_i
  assign ready_o = ~a_full_q | ~b_full_q;
  assign valid_o = a_full_q | b_full_q;
  // B is always the older beat
  assign data_o  = b_full_q ? b_data_q : a_data_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill || a_drain) begin
        a_full_q <= a_fill;
      end
      if (b_fill || b_drain) begin
        b_full_q <= b_fill;
      end
    end
  end

  // Payload slots
  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

endmodule

// File: tb_axi_lite_mux.sv
// Testbench for the AXI4-Lite mux: random managers, subordinate model and scoreboard
module tb_axi_lite_mux
  import axi_lite_mux_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_RAND = 12;
  localparam int N_HOLD = 8;
  localparam int N_RR   = 8;
  localparam int TOTAL_TRANS = NUM_PORTS * (2 * N_RAND + 2 * N_HOLD + N_RR);

  logic clk_i, arst_n_i;
  addr_t [NUM_PORTS-1:0] slv_aw_addr_i, slv_ar_addr_i;
  prot_t [NUM_PORTS-1:0] slv_aw_prot_i, slv_ar_prot_i;
  data_t [NUM_PORTS-1:0] slv_w_data_i, slv_r_data_o;
  strb_t [NUM_PORTS-1:0] slv_w_strb_i;
  resp_t [NUM_PORTS-1:0] slv_b_resp_o, slv_r_resp_o;
  logic  [NUM_PORTS-1:0] slv_aw_valid_i, slv_aw_ready_o, slv_w_valid_i, slv_w_ready_o;
  logic  [NUM_PORTS-1:0] slv_b_valid_o, slv_b_ready_i, slv_ar_valid_i, slv_ar_ready_o;
  logic  [NUM_PORTS-1:0] slv_r_valid_o, slv_r_ready_i;
  addr_t mst_aw_addr_o, mst_ar_addr_o;
  prot_t mst_aw_prot_o, mst_ar_prot_o;
  data_t mst_w_data_o, mst_r_data_i;
  strb_t mst_w_strb_o;
  resp_t mst_b_resp_i, mst_r_resp_i;
  logic  mst_aw_valid_o, mst_aw_ready_i, mst_w_valid_o, mst_w_ready_i;
  logic  mst_b_valid_i, mst_b_ready_o, mst_ar_valid_o, mst_ar_ready_i;
  logic  mst_r_valid_i, mst_r_ready_o;

  // Per port stimulus lists and progress counters
  addr_t wr_addr_q [NUM_PORTS][$];
  data_t wr_data_q [NUM_PORTS][$];
  strb_t wr_strb_q [NUM_PORTS][$];
  addr_t rd_addr_q [NUM_PORTS][$];
  int aw_idx [NUM_PORTS], w_idx [NUM_PORTS], b_idx [NUM_PORTS];
  int ar_idx [NUM_PORTS], r_idx [NUM_PORTS], w_chk [NUM_PORTS];
  // Scoreboard queues in upstream grant order
  addr_t exp_aw_q [$], exp_ar_q [$];
  prot_t exp_aw_prot_q [$], exp_ar_prot_q [$];
  sel_t  w_port_q [$];
  // Downstream W beats not yet matched to an upstream AW grant
  data_t w_data_seen_q [$];
  strb_t w_strb_seen_q [$];
  // Subordinate model state
  addr_t down_aw_addrs [$], down_ar_addrs [$];
  int down_w_cnt, b_sent, r_sent;
  int up_aw_cnt, up_ar_cnt;
  logic active, hold_b, hold_r, rr_mode, rr_have_prev;
  sel_t rr_prev;
  int rr_checked;
  int errors, checks, tests;

  axi_lite_mux i_dut (.*);

  // --------------------------------------------------
  // Clock, watchdog
  // --------------------------------------------------
  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  initial begin
    #(TOTAL_TRANS * 200 * 20);
    $display("Timeout, the transactions did not complete in time");
    $display("Simulation FAILED");
    $finish;
  end

  // --------------------------------------------------
  // Compare tasks
  // --------------------------------------------------
  task automatic cmp_addr(string name, addr_t exp, addr_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Fail at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic cmp_data(string name, data_t exp, data_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Fail at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic cmp_strb(string name, strb_t exp, strb_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Fail at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic cmp_prot(string name, prot_t exp, prot_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Fail at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic cmp_resp(string name, resp_t exp, resp_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Fail at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic cmp_sel(string name, sel_t exp, sel_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Fail at %0t: %s expected %0d got %0d", $time, name, exp, act);
    end
  endtask

  task automatic cmp_flags(string name, logic [NUM_PORTS-1:0] exp, logic [NUM_PORTS-1:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Fail at %0t: %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  task automatic check_limit(string what, int count, int limit);
    checks++;
    if (count > limit) begin
      errors++;
      $display("At %0t %s reached %0d, more than the limit of %0d", $time, what, count, limit);
    end
  endtask

  task automatic report_unexpected(string what);
    errors++;
    $display("At %0t an unexpected %s arrived", $time, what);
  endtask

  // Subordinate response rule, bit 12 selects an error
  function automatic resp_t resp_for(addr_t a);
    return a[12] ? RESP_SLVERR : RESP_OKAY;
  endfunction

  // Address carries the issuing port in its top bits
  task automatic load(int n_wr, int n_rd);
    for (int p = 0; p < NUM_PORTS; p++) begin
      for (int k = 0; k < n_wr; k++) begin
        wr_addr_q[p].push_back({sel_t'(p), 30'($urandom)});
        wr_data_q[p].push_back(data_t'($urandom));
        wr_strb_q[p].push_back(strb_t'($urandom));
      end
      for (int k = 0; k < n_rd; k++) begin
        rd_addr_q[p].push_back({sel_t'(p), 30'($urandom)});
      end
    end
  endtask

  function automatic logic all_done();
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (b_idx[p] != wr_addr_q[p].size() || r_idx[p] != rd_addr_q[p].size()) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  // --------------------------------------------------
  // Managers and subordinate, sampled and driven on the rising edge
  // --------------------------------------------------
  always @(posedge clk_i) begin
    logic busy;
    sel_t ps;
    if (active) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        // AW issue
        busy = slv_aw_valid_i[p];
        if (busy && slv_aw_ready_o[p]) begin
          exp_aw_q.push_back(slv_aw_addr_i[p]);
          exp_aw_prot_q.push_back(slv_aw_prot_i[p]);
          w_port_q.push_back(sel_t'(p));
          aw_idx[p]++;
          up_aw_cnt++;
          busy = 1'b0;
        end
        if (!busy) begin
          if (aw_idx[p] < wr_addr_q[p].size() && $urandom % 2 == 0) begin
            slv_aw_valid_i[p] <= 1'b1;
            slv_aw_addr_i[p]  <= wr_addr_q[p][aw_idx[p]];
            slv_aw_prot_i[p]  <= prot_t'($urandom);
          end else begin
            slv_aw_valid_i[p] <= 1'b0;
          end
        end
        // W issue, independent of AW
        busy = slv_w_valid_i[p];
        if (busy && slv_w_ready_o[p]) begin
          w_idx[p]++;
          busy = 1'b0;
        end
        if (!busy) begin
          if (w_idx[p] < wr_addr_q[p].size() && $urandom % 2 == 0) begin
            slv_w_valid_i[p] <= 1'b1;
            slv_w_data_i[p]  <= wr_data_q[p][w_idx[p]];
            slv_w_strb_i[p]  <= wr_strb_q[p][w_idx[p]];
          end else begin
            slv_w_valid_i[p] <= 1'b0;
          end
        end
        // AR issue, continuous in round-robin mode
        busy = slv_ar_valid_i[p];
        if (busy && slv_ar_ready_o[p]) begin
          exp_ar_q.push_back(slv_ar_addr_i[p]);
          exp_ar_prot_q.push_back(slv_ar_prot_i[p]);
          ar_idx[p]++;
          up_ar_cnt++;
          busy = 1'b0;
        end
        if (!busy) begin
          if (ar_idx[p] < rd_addr_q[p].size() && (rr_mode || $urandom % 2 == 0)) begin
            slv_ar_valid_i[p] <= 1'b1;
            slv_ar_addr_i[p]  <= rd_addr_q[p][ar_idx[p]];
            slv_ar_prot_i[p]  <= prot_t'($urandom);
          end else begin
            slv_ar_valid_i[p] <= 1'b0;
          end
        end
        // Responses, in issue order per port
        if (slv_b_valid_o[p] && slv_b_ready_i[p]) begin
          if (b_idx[p] >= wr_addr_q[p].size()) begin
            report_unexpected("B response");
          end else begin
            cmp_resp("slv_b_resp_o", resp_for(wr_addr_q[p][b_idx[p]]), slv_b_resp_o[p]);
            b_idx[p]++;
          end
        end
        if (slv_r_valid_o[p] && slv_r_ready_i[p]) begin
          if (r_idx[p] >= rd_addr_q[p].size()) begin
            report_unexpected("R response");
          end else begin
            cmp_data("slv_r_data_o", ~rd_addr_q[p][r_idx[p]], slv_r_data_o[p]);
            cmp_resp("slv_r_resp_o", resp_for(rd_addr_q[p][r_idx[p]]), slv_r_resp_o[p]);
            r_idx[p]++;
          end
        end
        slv_b_ready_i[p] <= ($urandom % 3 != 0);
        slv_r_ready_i[p] <= ($urandom % 3 != 0);
      end

      // Downstream AW and AR leave in upstream grant order
      if (mst_aw_valid_o && mst_aw_ready_i) begin
        if (exp_aw_q.size() == 0) begin
          report_unexpected("downstream AW");
        end else begin
          cmp_addr("mst_aw_addr_o", exp_aw_q.pop_front(), mst_aw_addr_o);
          cmp_prot("mst_aw_prot_o", exp_aw_prot_q.pop_front(), mst_aw_prot_o);
        end
        down_aw_addrs.push_back(mst_aw_addr_o);
      end
      if (mst_ar_valid_o && mst_ar_ready_i) begin
        if (exp_ar_q.size() == 0) begin
          report_unexpected("downstream AR");
        end else begin
          cmp_addr("mst_ar_addr_o", exp_ar_q.pop_front(), mst_ar_addr_o);
          cmp_prot("mst_ar_prot_o", exp_ar_prot_q.pop_front(), mst_ar_prot_o);
        end
        down_ar_addrs.push_back(mst_ar_addr_o);
        ps = mst_ar_addr_o[ADDR_W-1 -: 2];
        // Rotation through the ports while all keep requesting
        if (rr_mode && rr_checked < NUM_PORTS * (N_RR - 2)) begin
          if (rr_have_prev) begin
            cmp_sel("downstream AR port", sel_t'((int'(rr_prev) + 1) % NUM_PORTS), ps);
          end
          rr_have_prev = 1'b1;
          rr_prev = ps;
          rr_checked++;
        end
      end
      if (mst_w_valid_o && mst_w_ready_i) begin
        w_data_seen_q.push_back(mst_w_data_o);
        w_strb_seen_q.push_back(mst_w_strb_o);
        down_w_cnt++;
      end
      // A beat can pass while its AW is still locked before the spill stage
      while (w_port_q.size() > 0 && w_data_seen_q.size() > 0) begin
        ps = w_port_q.pop_front();
        cmp_data("mst_w_data_o", wr_data_q[ps][w_chk[ps]], w_data_seen_q.pop_front());
        cmp_strb("mst_w_strb_o", wr_strb_q[ps][w_chk[ps]], w_strb_seen_q.pop_front());
        w_chk[ps]++;
      end
      // Only the one locked AW can trail its beat
      if (w_data_seen_q.size() > 1) begin
        report_unexpected("downstream W");
        w_data_seen_q.delete(0);
        w_strb_seen_q.delete(0);
      end

      // Subordinate B, only once both AW and W of a write arrived
      busy = mst_b_valid_i;
      if (busy && mst_b_ready_o) begin
        b_sent++;
        busy = 1'b0;
      end
      if (!busy) begin
        if (!hold_b && b_sent < down_aw_addrs.size() && b_sent < down_w_cnt
            && $urandom % 2 == 0) begin
          mst_b_valid_i <= 1'b1;
          mst_b_resp_i  <= resp_for(down_aw_addrs[b_sent]);
        end else begin
          mst_b_valid_i <= 1'b0;
        end
      end
      // Subordinate R, data is the inverted address
      busy = mst_r_valid_i;
      if (busy && mst_r_ready_o) begin
        r_sent++;
        busy = 1'b0;
      end
      if (!busy) begin
        if (!hold_r && r_sent < down_ar_addrs.size() && $urandom % 2 == 0) begin
          mst_r_valid_i <= 1'b1;
          mst_r_data_i  <= ~down_ar_addrs[r_sent];
          mst_r_resp_i  <= resp_for(down_ar_addrs[r_sent]);
        end else begin
          mst_r_valid_i <= 1'b0;
        end
      end
      mst_aw_ready_i <= ($urandom % 4 != 0);
      mst_w_ready_i  <= ($urandom % 4 != 0);
      mst_ar_ready_i <= ($urandom % 4 != 0);
    end
  end

  task automatic finish_test(string name, int err_base);
    tests++;
    $display("Test %-12s %s, %0d errors", name, (errors == err_base) ? "ok" : "failed",
             errors - err_base);
  endtask

  // --------------------------------------------------
  // Test sequence, stepped on the falling edge
  // --------------------------------------------------
  initial begin
    int err_base;
    int aw_base, w_base, ar_base;
    void'($urandom(35916));
    arst_n_i = 1'b0;
    {slv_aw_addr_i, slv_aw_prot_i, slv_aw_valid_i} = '0;
    {slv_w_data_i, slv_w_strb_i, slv_w_valid_i} = '0;
    {slv_ar_addr_i, slv_ar_prot_i, slv_ar_valid_i} = '0;
    // Readies high while idle, so the idle outputs depend on the empty FIFOs
    slv_b_ready_i = '1;
    slv_r_ready_i = '1;
    {mst_aw_ready_i, mst_w_ready_i, mst_ar_ready_i} = '1;
    {mst_b_resp_i, mst_b_valid_i, mst_r_data_i, mst_r_resp_i, mst_r_valid_i} = '0;
    {active, hold_b, hold_r, rr_mode, rr_have_prev} = '0;
    {rr_prev, rr_checked, errors, checks, tests} = '0;
    {down_w_cnt, b_sent, r_sent, up_aw_cnt, up_ar_cnt} = '0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      {aw_idx[p], w_idx[p], b_idx[p], ar_idx[p], r_idx[p], w_chk[p]} = '0;
    end
    repeat (2) @(posedge clk_i);
    arst_n_i <= 1'b1;

    // Idle outputs after reset
    @(negedge clk_i);
    err_base = errors;
    cmp_flags("slv_aw_ready_o", '0, slv_aw_ready_o);
    cmp_flags("slv_w_ready_o", '0, slv_w_ready_o);
    cmp_flags("slv_b_valid_o", '0, slv_b_valid_o);
    cmp_flags("slv_ar_ready_o", '0, slv_ar_ready_o);
    cmp_flags("slv_r_valid_o", '0, slv_r_valid_o);
    cmp_flags("{mst_aw_valid_o, mst_w_valid_o, mst_b_ready_o, mst_ar_valid_o}",
              '0, {mst_aw_valid_o, mst_w_valid_o, mst_b_ready_o, mst_ar_valid_o});
    cmp_flags("mst_r_ready_o", '0, {3'b000, mst_r_ready_o});
    finish_test("reset", err_base);

    // Random mixed traffic
    err_base = errors;
    load(N_RAND, N_RAND);
    active = 1'b1;
    while (!all_done()) @(negedge clk_i);
    finish_test("random", err_base);

    // Responses held back, routing FIFOs fill and stall
    err_base = errors;
    hold_b  = 1'b1;
    hold_r  = 1'b1;
    aw_base = up_aw_cnt;
    w_base  = down_w_cnt;
    ar_base = up_ar_cnt;
    load(N_HOLD, N_HOLD);
    repeat (100) @(negedge clk_i);
    // AW may fill the W route and the B route behind it
    check_limit("upstream AW count with B held", up_aw_cnt - aw_base, 2 * MAX_TRANS);
    check_limit("downstream W count with B held", down_w_cnt - w_base, MAX_TRANS);
    check_limit("upstream AR count with R held", up_ar_cnt - ar_base, MAX_TRANS);
    hold_b = 1'b0;
    hold_r = 1'b0;
    while (!all_done()) @(negedge clk_i);
    finish_test("backpressure", err_base);

    // All ports request AR back to back
    err_base = errors;
    rr_mode = 1'b1;
    load(0, N_RR);
    while (!all_done()) @(negedge clk_i);
    rr_mode = 1'b0;
    finish_test("round_robin", err_base);

    // Every downstream W beat found its AW
    if (w_data_seen_q.size() != 0) begin
      report_unexpected("downstream W");
    end

    $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: write_mux.sv
// Write path of the mux: AW arbitration, W steering and B response routing
module write_mux
  import axi_lite_mux_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  // Upstream managers
  input  addr_t [NUM_PORTS-1:0] slv_aw_addr_i,
  input  prot_t [NUM_PORTS-1:0] slv_aw_prot_i,
  input  logic  [NUM_PORTS-1:0] slv_aw_valid_i,
  output logic  [NUM_PORTS-1:0] slv_aw_ready_o,
  input  data_t [NUM_PORTS-1:0] slv_w_data_i,
  input  strb_t [NUM_PORTS-1:0] slv_w_strb_i,
  input  logic  [NUM_PORTS-1:0] slv_w_valid_i,
  output logic  [NUM_PORTS-1:0] slv_w_ready_o,
  output resp_t [NUM_PORTS-1:0] slv_b_resp_o,
  output logic  [NUM_PORTS-1:0] slv_b_valid_o,
  input  logic  [NUM_PORTS-1:0] slv_b_ready_i,
  // Downstream subordinate
  output addr_t                 mst_aw_addr_o,
  output prot_t                 mst_aw_prot_o,
  output logic                  mst_aw_valid_o,
  input  logic                  mst_aw_ready_i,
  output data_t                 mst_w_data_o,
  output strb_t                 mst_w_strb_o,
  output logic                  mst_w_valid_o,
  input  logic                  mst_w_ready_i,
  input  resp_t                 mst_b_resp_i,
  input  logic                  mst_b_valid_i,
  output logic                  mst_b_ready_o
);

  logic [NUM_PORTS-1:0][AX_W-1:0] slv_aw_chans;
  logic [AX_W-1:0] aw_chan, mst_aw_chan;
  sel_t aw_sel, w_sel, b_sel;
  logic aw_req, aw_gnt;
  logic aw_spill_valid, aw_spill_ready;
  // Set once the AW index is in the W FIFO but the spill stage stalled
  logic lock_aw_d, lock_aw_q;
  logic w_fifo_push, w_fifo_pop, w_fifo_full, w_fifo_empty;
  logic b_fifo_pop, b_fifo_full, b_fifo_empty;
  logic w_route_ok;

  // --------------------------------------------------
  // AW channel
  // --------------------------------------------------
  for (genvar i = 0; i < NUM_PORTS; i++) begin : gen_aw_chans
    assign slv_aw_chans[i] = {slv_aw_prot_i[i], slv_aw_addr_i[i]};
  end

  rr_arbiter #(
    .WIDTH ( AX_W )
  ) i_aw_arbiter (
    .clk_i    ( clk_i          ),
    .arst_n_i ( arst_n_i       ),
    .req_i    ( slv_aw_valid_i ),
    .gnt_o    ( slv_aw_ready_o ),
    .data_i   ( slv_aw_chans   ),
    .req_o    ( aw_req         ),
    .gnt_i    ( aw_gnt         ),
    .data_o   ( aw_chan        ),
    .idx_o    ( aw_sel         )
  );

  // Push the W route once per AW, hold valid until the spill stage takes it
  always_comb begin
    lock_aw_d      = lock_aw_q;
    w_fifo_push    = 1'b0;
    aw_spill_valid = 1'b0;
    aw_gnt         = 1'b0;
    if (lock_aw_q) begin
      aw_spill_valid = 1'b1;
      if (aw_spill_ready) begin
        aw_gnt    = 1'b1;
        lock_aw_d = 1'b0;
      end
    end else if (aw_req && !w_fifo_full) begin
      aw_spill_valid = 1'b1;
      w_fifo_push    = 1'b1;
      if (aw_spill_ready) begin
        aw_gnt = 1'b1;
      end else begin
        lock_aw_d = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lock_aw_q <= 1'b0;
    end else begin
      lock_aw_q <= lock_aw_d;
    end
  end

  spill_register #(
    .WIDTH ( AX_W )
  ) i_aw_spill (
    .clk_i    ( clk_i          ),
    .arst_n_i ( arst_n_i       ),
    .valid_i  ( aw_spill_valid ),
    .ready_o  ( aw_spill_ready ),
    .data_i   ( aw_chan        ),
    .valid_o  ( mst_aw_valid_o ),
    .ready_i  ( mst_aw_ready_i ),
    .data_o   ( mst_aw_chan    )
  );

  assign {mst_aw_prot_o, mst_aw_addr_o} = mst_aw_chan;

  route_fifo #(
    .DEPTH ( MAX_TRANS )
  ) i_w_fifo (
    .clk_i    ( clk_i        ),
    .arst_n_i ( arst_n_i     ),
    .push_i   ( w_fifo_push  ),
    .data_i   ( aw_sel       ),
    .pop_i    ( w_fifo_pop   ),
    .data_o   ( w_sel        ),
    .full_o   ( w_fifo_full  ),
    .empty_o  ( w_fifo_empty )
  );

  // --------------------------------------------------
  // W channel
  // --------------------------------------------------
  // Route known and room for the B route
  assign w_route_ok    = ~w_fifo_empty & ~b_fifo_full;
  assign mst_w_data_o  = slv_w_data_i[w_sel];
  assign mst_w_strb_o  = slv_w_strb_i[w_sel];
  assign mst_w_valid_o = w_route_ok & slv_w_valid_i[w_sel];
  assign w_fifo_pop    = mst_w_valid_o & mst_w_ready_i;

  for (genvar i = 0; i < NUM_PORTS; i++) begin : gen_w_ready
    assign slv_w_ready_o[i] = mst_w_ready_i & w_route_ok & (w_sel == sel_t'(i));
  end

  // Each W beat sent records where its B goes
  route_fifo #(
    .DEPTH ( MAX_TRANS )
  ) i_b_fifo (
    .clk_i    ( clk_i        ),
    .arst_n_i ( arst_n_i     ),
    .push_i   ( w_fifo_pop   ),
    .data_i   ( w_sel        ),
    .pop_i    ( b_fifo_pop   ),
    .data_o   ( b_sel        ),
    .full_o   ( b_fifo_full  ),
    .empty_o  ( b_fifo_empty )
  );

  // --------------------------------------------------
  // B channel
  // --------------------------------------------------
  for (genvar i = 0; i < NUM_PORTS; i++) begin : gen_b_resp
    assign slv_b_resp_o[i]  = mst_b_resp_i;
    assign slv_b_valid_o[i] = mst_b_valid_i & ~b_fifo_empty & (b_sel == sel_t'(i));
  end

  assign mst_b_ready_o = ~b_fifo_empty & slv_b_ready_i[b_sel];
  assign b_fifo_pop    = mst_b_valid_i & mst_b_ready_o;

endmodule
